// File: source/bip_pkg.sv
package bip_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and depths
    ////////////////////////////////////////////////////////////

    // Accumulator and data memory word
    localparam int NB_DATA    = 16;
    // Instruction fields
    localparam int NB_OPCODE  = 5;
    localparam int NB_OPERAND = 11;
    // Same address width for both memories
    localparam int NB_ADDR    = 11;

    // Full address space of each memory
    localparam int PROG_DEPTH = 2048;
    localparam int DATA_DEPTH = 2048;

    ////////////////////////////////////////////////////////////
    // Words and instructions
    ////////////////////////////////////////////////////////////

    typedef logic [NB_DATA-1:0] data_t;
    typedef logic [NB_ADDR-1:0] addr_t;

    // Supported operations, any other code behaves as HLT
    typedef enum logic [NB_OPCODE-1:0] {
        OP_HLT  = 5'd0,
        OP_STO  = 5'd1,
        OP_LD   = 5'd2,
        OP_LDI  = 5'd3,
        OP_ADD  = 5'd4,
        OP_ADDI = 5'd5,
        OP_SUB  = 5'd6,
        OP_SUBI = 5'd7
    } opcode_e;

    // Opcode in the upper bits, operand in the lower bits
    typedef struct packed {
        logic [NB_OPCODE-1:0]  opcode;
        logic [NB_OPERAND-1:0] operand;
    } instr_t;

    ////////////////////////////////////////////////////////////
    // Datapath controls
    ////////////////////////////////////////////////////////////

    // Accumulator source, 2'b11 unused
    typedef enum logic [1:0] {
        SEL_A_MEM = 2'b00,
        SEL_A_IMM = 2'b01,
        SEL_A_ALU = 2'b10
    } sel_a_e;

    // Second ALU operand
    typedef enum logic {
        SEL_B_MEM = 1'b0,
        SEL_B_IMM = 1'b1
    } sel_b_e;

    typedef struct packed {
        sel_a_e sel_a;
        sel_b_e sel_b;
        logic   wr_acc;
        logic   op_sub;
    } dp_ctrl_t;

endpackage

// File: source/bip_memory.sv
`timescale 1ns/1ps

module bip_memory #(
    // Payload of one word
    parameter type word_t = bip_pkg::data_t,
    // Number of words
    parameter int  DEPTH  = bip_pkg::DATA_DEPTH
) (
    input  logic           i_clk,
    input  logic           i_rst,
    // Write port
    input  logic           i_wr_en,
    input  bip_pkg::addr_t i_wr_addr,
    input  bip_pkg::addr_t i_rd_addr,
    input  word_t          i_wr_data,
    // Read port, combinational
    output word_t          o_rd_data
);

    // Storage array
    word_t mem [DEPTH];

    ////////////////////////////////////////////////////////////
    // Write
    ////////////////////////////////////////////////////////////

    // Word written at the rising edge
    // visible on the read port from the next cycle
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read
    ////////////////////////////////////////////////////////////

    // Asynchronous read, lets fetch and execute share one cycle
    assign o_rd_data = mem[i_rd_addr];

    // An unknown enable would corrupt an unknown set of words
    a_wr_en_known : assert property (
        @(posedge i_clk) disable iff (!i_rst)
        !$isunknown(i_wr_en)
    ) else $error("bip_memory: write enable is unknown");

endmodule

// File: source/bip_datapath.sv
`timescale 1ns/1ps

module bip_datapath (
    input  logic              i_clk,
    input  logic              i_rst,
    // From control
    input  bip_pkg::dp_ctrl_t i_ctrl,
    input  logic              i_clr_acc,
    // Fetched instruction
    input  bip_pkg::instr_t   i_instr,
    // Data memory read word
    input  bip_pkg::data_t    i_data_memory,
    // Data memory address and write word
    output bip_pkg::addr_t    o_addr,
    output bip_pkg::data_t    o_data_memory,
    output bip_pkg::data_t    o_acc
);

    import bip_pkg::*;

    data_t imm_ext;
    data_t mux_a_out;
    data_t mux_b_out;
    data_t alu_out;
    data_t acc;

    ////////////////////////////////////////////////////////////
    // Operand handling
    ////////////////////////////////////////////////////////////

    // Sign extension of the 11 bit operand
    assign imm_ext = {{(NB_DATA-NB_OPERAND){i_instr.operand[NB_OPERAND-1]}}, i_instr.operand};

    // Second operand, memory word or immediate
    assign mux_b_out = (i_ctrl.sel_b == SEL_B_IMM) ? imm_ext : i_data_memory;

    // Add or subtract, wraps modulo 2^16
    assign alu_out = i_ctrl.op_sub ? (acc - mux_b_out) : (acc + mux_b_out);

    // Accumulator source
    always_comb begin
        case (i_ctrl.sel_a)
            SEL_A_MEM: mux_a_out = i_data_memory;
            SEL_A_IMM: mux_a_out = imm_ext;
            SEL_A_ALU: mux_a_out = alu_out;
            default:   mux_a_out = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Accumulator
    ////////////////////////////////////////////////////////////

    // Rising edge, clear on start has priority over a write
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            acc <= '0;
        end else if (i_clr_acc) begin
            acc <= '0;
        end else if (i_ctrl.wr_acc) begin
            acc <= mux_a_out;
        end
    end

    // Operand doubles as the direct data address
    assign o_addr        = i_instr.operand;
    assign o_data_memory = acc;
    assign o_acc         = acc;

    // Decoder must never pick the spare source for a write
    a_sel_a_legal : assert property (
        @(posedge i_clk) disable iff (!i_rst)
        i_ctrl.wr_acc |-> (i_ctrl.sel_a != 2'b11)
    ) else $error("bip_datapath: accumulator written from unused source");

endmodule

// File: source/bip_control.sv
`timescale 1ns/1ps

module bip_control (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_start,
    // Word read from program memory at o_pc
    input  bip_pkg::instr_t   i_instr,
    output bip_pkg::addr_t    o_pc,
    // To datapath
    output bip_pkg::dp_ctrl_t o_ctrl,
    output logic              o_clr_acc,
    // Data memory write enable
    output logic              o_wr_ram,
    // Status
    output logic              o_idle,
    output logic              o_running,
    output logic              o_halted
);

    import bip_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_RUN  = 2'b01,
        ST_HALT = 2'b10
    } state_e;

    state_e   state;
    addr_t    pc;
    logic     start_ok;
    logic     is_halt;
    dp_ctrl_t dec_ctrl;
    logic     dec_wr_ram;

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    // Start only accepted when not executing
    assign start_ok = i_start && (state != ST_RUN);

    always_comb begin
        dec_ctrl   = '{sel_a: SEL_A_MEM, sel_b: SEL_B_MEM, wr_acc: 1'b0, op_sub: 1'b0};
        dec_wr_ram = 1'b0;
        is_halt    = 1'b0;
        case (i_instr.opcode)
            OP_STO:  dec_wr_ram = 1'b1;
            OP_LD:   dec_ctrl = '{SEL_A_MEM, SEL_B_MEM, 1'b1, 1'b0};
            OP_LDI:  dec_ctrl = '{SEL_A_IMM, SEL_B_IMM, 1'b1, 1'b0};
            OP_ADD:  dec_ctrl = '{SEL_A_ALU, SEL_B_MEM, 1'b1, 1'b0};
            OP_ADDI: dec_ctrl = '{SEL_A_ALU, SEL_B_IMM, 1'b1, 1'b0};
            OP_SUB:  dec_ctrl = '{SEL_A_ALU, SEL_B_MEM, 1'b1, 1'b1};
            OP_SUBI: dec_ctrl = '{SEL_A_ALU, SEL_B_IMM, 1'b1, 1'b1};
            // HLT and undefined codes
            default: is_halt = 1'b1;
        endcase
    end

    // Side effects only while running
    assign o_ctrl    = (state == ST_RUN) ? dec_ctrl : '0;
    assign o_wr_ram  = (state == ST_RUN) && dec_wr_ram;
    assign o_clr_acc = start_ok;

    ////////////////////////////////////////////////////////////
    // State and PC
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            state <= ST_IDLE;
            pc    <= '0;
        end else if (start_ok) begin
            state <= ST_RUN;
            pc    <= '0;
        end else if (state == ST_RUN) begin
            // PC parks on the HLT address
            if (is_halt) begin
                state <= ST_HALT;
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

    assign o_pc      = pc;
    // Program memory may be loaded outside the run state
    assign o_idle    = (state != ST_RUN);
    assign o_running = (state == ST_RUN);
    assign o_halted  = (state == ST_HALT);

    // PC frozen while halted
    a_pc_frozen : assert property (
        @(posedge i_clk) disable iff (!i_rst)
        (o_halted && !i_start) |=> $stable(o_pc)
    ) else $error("bip_control: PC moved while halted");

    // Data memory written only in a run entered through start
    a_wr_ram_run : assert property (
        @(posedge i_clk) disable iff (!i_rst)
        o_wr_ram |-> ($past(start_ok) || $past(o_running))
    ) else $error("bip_control: data memory write outside run state");

endmodule

// File: source/bip_cpu.sv
`timescale 1ns/1ps

module bip_cpu (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_start,
    // Program load port
    input  logic            i_load_en,
    input  bip_pkg::addr_t  i_load_addr,
    input  bip_pkg::instr_t i_load_instr,
    // Observation
    output bip_pkg::data_t  o_acc,
    output bip_pkg::addr_t  o_pc,
    output logic            o_running,
    output logic            o_halted
);

    import bip_pkg::*;

    instr_t   instr;
    addr_t    pc;
    dp_ctrl_t dp_ctrl;
    logic     clr_acc;
    logic     wr_ram;
    logic     idle;
    logic     load_en;
    addr_t    data_addr;
    data_t    data_rd;
    data_t    data_wr;

    ////////////////////////////////////////////////////////////
    // Control and datapath
    ////////////////////////////////////////////////////////////

    bip_control u_control (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_start   (i_start),
        .i_instr   (instr),
        .o_pc      (pc),
        .o_ctrl    (dp_ctrl),
        .o_clr_acc (clr_acc),
        .o_wr_ram  (wr_ram),
        .o_idle    (idle),
        .o_running (o_running),
        .o_halted  (o_halted)
    );

    bip_datapath u_datapath (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_ctrl        (dp_ctrl),
        .i_clr_acc     (clr_acc),
        .i_instr       (instr),
        .i_data_memory (data_rd),
        .o_addr        (data_addr),
        .o_data_memory (data_wr),
        .o_acc         (o_acc)
    );

    ////////////////////////////////////////////////////////////
    // Memories
    ////////////////////////////////////////////////////////////

    // Loads ignored while a program executes
    assign load_en = i_load_en & idle;

    bip_memory #(.word_t(instr_t), .DEPTH(PROG_DEPTH)) u_prog_memory (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_wr_en   (load_en),
        .i_wr_addr (i_load_addr),
        .i_rd_addr (pc),
        .i_wr_data (i_load_instr),
        .o_rd_data (instr)
    );

    // Same address for LD and STO
    bip_memory #(.word_t(data_t), .DEPTH(DATA_DEPTH)) u_data_memory (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_wr_en   (wr_ram),
        .i_wr_addr (data_addr),
        .i_rd_addr (data_addr),
        .i_wr_data (data_wr),
        .o_rd_data (data_rd)
    );

    assign o_pc = pc;

endmodule

// File: sim/bip_clock_gen.sv
`timescale 1ns/1ps

module bip_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic o_clk,
    output logic o_rst
);

    // Free running clock, starts low
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Active low, held over the first rising edges, released on a falling edge
    initial begin
        o_rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b1;
    end

endmodule

// File: sim/bip_cpu_tb.sv
`timescale 1ns/1ps

module bip_cpu_tb;

    import bip_pkg::*;

    localparam int CLK_PERIOD_NS  = 40;
    localparam int RESET_CYCLES   = 3;
    // Watchdog budget
    localparam int N_PROGRAMS     = 8;
    localparam int PROGRAM_CYCLES = 70;
    localparam int WATCHDOG_NS    = (N_PROGRAMS * PROGRAM_CYCLES + RESET_CYCLES) * CLK_PERIOD_NS;
    // Longest wait for o_halted in one run
    localparam int MAX_RUN_CYCLES = 100;
    localparam int N_RANDOM       = 3;

    logic   clk;
    logic   rst;
    logic   start;
    logic   load_en;
    addr_t  load_addr;
    instr_t load_instr;
    data_t  dut_acc;
    addr_t  dut_pc;
    logic   running;
    logic   halted;

    // Program under test and the reference data memory
    instr_t program_q [$];
    data_t  model_mem [DATA_DEPTH];
    bit     mem_valid [DATA_DEPTH];

    int     total_errors = 0;
    int     test_errors  = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;
    // Snapshot taken at the falling edge after the start edge
    addr_t  start_pc;
    data_t  start_acc;

    bip_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    bip_cpu uut (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_start      (start),
        .i_load_en    (load_en),
        .i_load_addr  (load_addr),
        .i_load_instr (load_instr),
        .o_acc        (dut_acc),
        .o_pc         (dut_pc),
        .o_running    (running),
        .o_halted     (halted)
    );

    ////////////////////////////////////////////////////////////
    // Reference model and compare tasks
    ////////////////////////////////////////////////////////////

    function automatic instr_t make_instr(input logic [4:0] opcode, input logic [10:0] operand);
        instr_t w;
        w.opcode  = opcode;
        w.operand = operand;
        return w;
    endfunction

    // ISA interpreter running from address 0 until HLT
    function automatic void run_model(output data_t acc, output addr_t pc);
        instr_t ins;
        int     sval;
        data_t  imm;
        bit     done;
        acc  = '0;
        pc   = '0;
        done = 1'b0;
        while (!done && int'(pc) < program_q.size()) begin
            ins  = program_q[pc];
            // Immediate is a signed 11 bit value
            sval = $signed(ins.operand);
            imm  = data_t'(sval);
            case (ins.opcode)
                OP_STO: begin
                    model_mem[ins.operand] = acc;
                    mem_valid[ins.operand] = 1'b1;
                end
                OP_LD:   acc = model_mem[ins.operand];
                OP_LDI:  acc = imm;
                OP_ADD:  acc = acc + model_mem[ins.operand];
                OP_ADDI: acc = acc + imm;
                OP_SUB:  acc = acc - model_mem[ins.operand];
                OP_SUBI: acc = acc - imm;
                default: done = 1'b1;
            endcase
            if (!done) begin
                pc = pc + 1'b1;
            end
        end
    endfunction

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
            $display("FAIL %s (%0d errors)", name, test_errors);
        end else begin
            $display("ok   %s", name);
        end
        test_errors = 0;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // One word per cycle through the load port
    task automatic load_program();
        foreach (program_q[i]) begin
            @(negedge clk);
            load_en    = 1'b1;
            load_addr  = addr_t'(i);
            load_instr = program_q[i];
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic run_program(input string name, output bit halted_ok);
        int cycles;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start     = 1'b0;
        start_pc  = dut_pc;
        start_acc = dut_acc;
        // Run state entered at the start edge
        check_flag({name, " running after start"}, 1'b1, running);
        check_flag({name, " halted after start"}, 1'b0, halted);
        cycles    = 0;
        while (halted !== 1'b1 && cycles < MAX_RUN_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        halted_ok = (halted === 1'b1);
        if (!halted_ok) begin
            $display("%s: core did not halt within %0d cycles", name, MAX_RUN_CYCLES);
            test_errors++;
        end
    endtask

    // Model run before the DUT run, then accumulator and PC compared
    task automatic execute_and_compare(input string name, output data_t exp_acc,
                                       output addr_t exp_pc);
        bit ok;
        run_model(exp_acc, exp_pc);
        run_program(name, ok);
        if (ok) begin
            check_data(name, exp_acc, dut_acc);
            check_addr(name, exp_pc, dut_pc);
        end
    endtask

    // Reads only from addresses already written
    // Unwritten words hold unknowns
    task automatic build_random_program();
        int          len;
        logic [4:0]  op;
        logic [10:0] opnd;
        program_q.delete();
        len = $urandom_range(59, 20);
        repeat (len) begin
            op   = 5'($urandom_range(7, 1));
            opnd = 11'($urandom);
            if (op == OP_STO || op == OP_LD || op == OP_ADD || op == OP_SUB) begin
                opnd = 11'($urandom_range(15, 0));
                if (op != OP_STO && !mem_valid[opnd]) begin
                    op = OP_STO;
                end
                if (op == OP_STO) begin
                    mem_valid[opnd] = 1'b1;
                end
            end
            program_q.push_back(make_instr(op, opnd));
        end
        program_q.push_back(make_instr(OP_HLT, 11'd0));
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic idle_after_reset();
        wait (rst === 1'b1);
        @(negedge clk);
        check_flag("idle_after_reset running", 1'b0, running);
        check_flag("idle_after_reset halted", 1'b0, halted);
        check_data("idle_after_reset acc", '0, dut_acc);
        check_addr("idle_after_reset pc", '0, dut_pc);
        report_test("idle_after_reset");
    endtask

    // Negative operands and wrap in both directions
    task automatic immediate_arith();
        data_t e_acc;
        addr_t e_pc;
        program_q.delete();
        program_q.push_back(make_instr(OP_LDI, 11'h7FF));
        program_q.push_back(make_instr(OP_ADDI, 11'd2));
        program_q.push_back(make_instr(OP_SUBI, 11'd3));
        program_q.push_back(make_instr(OP_ADDI, 11'h400));
        program_q.push_back(make_instr(OP_SUBI, 11'h400));
        program_q.push_back(make_instr(OP_LDI, 11'd1023));
        program_q.push_back(make_instr(OP_ADDI, 11'd1023));
        program_q.push_back(make_instr(OP_SUBI, 11'h7FE));
        program_q.push_back(make_instr(OP_HLT, 11'd0));
        load_program();
        execute_and_compare("immediate_arith", e_acc, e_pc);
        report_test("immediate_arith");
    endtask

    // Values stored far apart and combined only through LD, ADD and SUB
    task automatic memory_access();
        data_t e_acc;
        addr_t e_pc;
        program_q.delete();
        program_q.push_back(make_instr(OP_LDI, 11'd300));
        program_q.push_back(make_instr(OP_STO, 11'd100));
        program_q.push_back(make_instr(OP_LDI, 11'h7F9));
        program_q.push_back(make_instr(OP_STO, 11'd2047));
        program_q.push_back(make_instr(OP_LDI, 11'd0));
        program_q.push_back(make_instr(OP_LD, 11'd100));
        program_q.push_back(make_instr(OP_ADD, 11'd2047));
        program_q.push_back(make_instr(OP_STO, 11'd1024));
        program_q.push_back(make_instr(OP_SUB, 11'd100));
        program_q.push_back(make_instr(OP_LDI, 11'd5));
        program_q.push_back(make_instr(OP_ADD, 11'd1024));
        program_q.push_back(make_instr(OP_SUB, 11'd2047));
        program_q.push_back(make_instr(OP_HLT, 11'd0));
        load_program();
        execute_and_compare("memory_access", e_acc, e_pc);
        report_test("memory_access");
    endtask

    task automatic halt_and_park();
        data_t e_acc;
        addr_t e_pc;
        // Word after HLT must never execute
        program_q.delete();
        program_q.push_back(make_instr(OP_LDI, 11'd77));
        program_q.push_back(make_instr(OP_ADDI, 11'h7F9));
        program_q.push_back(make_instr(OP_HLT, 11'd0));
        program_q.push_back(make_instr(OP_LDI, 11'd5));
        load_program();
        execute_and_compare("halt_and_park", e_acc, e_pc);
        repeat (8) @(negedge clk);
        check_data("halt_and_park acc stable", e_acc, dut_acc);
        check_addr("halt_and_park pc stable", e_pc, dut_pc);
        check_flag("halt_and_park halted", 1'b1, halted);
        check_flag("halt_and_park running", 1'b0, running);
        // Undefined opcode 19 stops the core like HLT
        program_q.delete();
        program_q.push_back(make_instr(OP_ADDI, 11'd21));
        program_q.push_back(make_instr(OP_SUBI, 11'd4));
        program_q.push_back(make_instr(5'd19, 11'd0));
        program_q.push_back(make_instr(OP_ADDI, 11'd9));
        load_program();
        execute_and_compare("halt_and_park undefined", e_acc, e_pc);
        repeat (8) @(negedge clk);
        check_data("halt_and_park undefined acc stable", e_acc, dut_acc);
        check_addr("halt_and_park undefined pc stable", e_pc, dut_pc);
        check_flag("halt_and_park undefined halted", 1'b1, halted);
        report_test("halt_and_park");
    endtask

    // Same program again without a reload
    task automatic restart_clears();
        data_t e_acc;
        addr_t e_pc;
        execute_and_compare("restart_clears", e_acc, e_pc);
        check_addr("restart_clears pc after start", '0, start_pc);
        check_data("restart_clears acc after start", '0, start_acc);
        report_test("restart_clears");
    endtask

    task automatic random_programs();
        data_t e_acc;
        addr_t e_pc;
        for (int n = 0; n < N_RANDOM; n++) begin
            build_random_program();
            load_program();
            execute_and_compare($sformatf("random_programs[%0d]", n), e_acc, e_pc);
        end
        report_test("random_programs");
    endtask

    ////////////////////////////////////////////////////////////
    // Sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        start      = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_instr = '0;
        void'($urandom(75916));
        idle_after_reset();
        immediate_arith();
        memory_access();
        halt_and_park();
        restart_clears();
        random_programs();
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: sources.f
source/bip_pkg.sv
source/bip_memory.sv
source/bip_datapath.sv
source/bip_control.sv
source/bip_cpu.sv
sim/bip_clock_gen.sv
sim/bip_cpu_tb.sv

// File: Bender.yml
package:
  name: bip_cpu

sources:
  - target: any(rtl, simulation)
    files:
      - source/bip_pkg.sv
      - source/bip_memory.sv
      - source/bip_datapath.sv
      - source/bip_control.sv
      - source/bip_cpu.sv
  - target: simulation
    files:
      - sim/bip_clock_gen.sv
      - sim/bip_cpu_tb.sv
